// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_dcache
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== common/dcache_pkg.sv ====
////////////////////
// data cache types
// field widths, request structs and controller states
////////////////////
`include "dcache_settings.svh"

package dcache_pkg;

    localparam int BYTE_OFF_W = $clog2(`DCACHE_WORD_W / 8);
    localparam int WORD_SEL_W = $clog2(`DCACHE_LINE_WORDS);
    localparam int INDEX_W    = $clog2(`DCACHE_SETS);
    localparam int TAG_W      = `DCACHE_ADDR_W - INDEX_W - WORD_SEL_W - BYTE_OFF_W;
    localparam int WAY_W      = $clog2(`DCACHE_WAYS);

    typedef logic [`DCACHE_ADDR_W-1:0]   addr_t;
    typedef logic [`DCACHE_WORD_W-1:0]   word_t;
    typedef logic [`DCACHE_WORD_W/8-1:0] strb_t;
    typedef logic [TAG_W-1:0]            tag_t;
    typedef logic [INDEX_W-1:0]          index_t;
    typedef logic [WORD_SEL_W-1:0]       word_sel_t;
    typedef logic [WAY_W-1:0]            way_t;

    // cpu load/store request
    typedef struct packed {
        logic  write;
        addr_t addr;
        word_t wdata;
        strb_t wstrb;
    } cpu_req_t;

    // one word beat towards memory
    typedef struct packed {
        logic  write;
        addr_t addr;   // word aligned
        word_t wdata;
    } mem_req_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL_REQ,
        REFILL_RESP,
        REPLAY
    } ctrl_state_t;

endpackage

// ==== common/dcache_settings.svh ====
////////////////////
// data cache geometry
// widths and sizes shared by the package and the storage arrays
////////////////////
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

`define DCACHE_ADDR_W      32 // byte address
`define DCACHE_WORD_W      32
// one lru bit per set only covers two ways
`define DCACHE_WAYS        2
`define DCACHE_SETS        16 // small so evictions come quickly
`define DCACHE_LINE_WORDS  4

`endif

// ==== dcache/beat_counter.sv ====
////////////////////
// line beat counter
// steps through the words of one line transfer
////////////////////
`timescale 1ns/1ps
`include "dcache_settings.svh"

module beat_counter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  clear,
    input  logic                  advance,
    output dcache_pkg::word_sel_t beat,
    output logic                  last_beat
);
    import dcache_pkg::*;

    assign last_beat = (beat == word_sel_t'(`DCACHE_LINE_WORDS - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beat <= '0;
        end else if (clear) begin
            beat <= '0;
        end else if (advance) begin
            // wrap after the final word
            beat <= last_beat ? '0 : beat + 1'b1;
        end
    end

endmodule

// ==== dcache/data_store.sv ====
////////////////////
// cache data array
// word reads, refill writes and byte-strobe store writes
////////////////////
`timescale 1ns/1ps
`include "dcache_settings.svh"

module data_store (
    input  logic                  clk,
    input  dcache_pkg::index_t    index,
    input  dcache_pkg::word_sel_t word_sel,
    input  dcache_pkg::way_t      way,
    input  logic                  we,
    input  dcache_pkg::strb_t     wstrb,
    input  dcache_pkg::word_t     wdata,
    input  logic                  src_mem,
    input  dcache_pkg::word_t     mem_word,
    output dcache_pkg::word_t     rdata
);
    import dcache_pkg::*;

    word_t mem [`DCACHE_WAYS][`DCACHE_SETS][`DCACHE_LINE_WORDS];

    assign rdata = mem[way][index][word_sel];

    always_ff @(posedge clk) begin
        if (we) begin
            if (src_mem) begin
                mem[way][index][word_sel] <= mem_word; // refill takes the whole word
            end else begin
                for (int b = 0; b < $bits(strb_t); b++) begin
                    if (wstrb[b]) mem[way][index][word_sel][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== dcache/dcache_ctrl.sv ====
////////////////////
// dcache controller
// accepts one request, completes hits, runs write-back and refill
////////////////////
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cpu_req_valid,
    input  dcache_pkg::cpu_req_t  cpu_req,
    output logic                  cpu_req_ready,
    output logic                  cpu_resp_valid,
    output logic                  mem_req_valid,
    output dcache_pkg::mem_req_t  mem_req,
    input  logic                  mem_req_ready,
    input  logic                  mem_resp_valid,
    input  logic                  hit,
    input  dcache_pkg::way_t      hit_way,
    input  dcache_pkg::way_t      victim_way,
    input  logic                  victim_dirty,
    input  dcache_pkg::tag_t      victim_tag,
    input  dcache_pkg::word_sel_t beat,
    input  logic                  last_beat,
    output logic                  beat_clear,
    output logic                  beat_advance,
    output dcache_pkg::index_t    index,
    output dcache_pkg::tag_t      tag,
    output dcache_pkg::word_sel_t word_sel,
    output dcache_pkg::strb_t     wstrb,
    output dcache_pkg::word_t     wdata,
    output logic                  tag_install,
    output logic                  lru_touch,
    output logic                  dirty_set,
    output logic                  data_we,
    output dcache_pkg::way_t      data_way,
    output logic                  data_src_mem
);
    import dcache_pkg::*;

    ctrl_state_t state, state_next;
    cpu_req_t    req_q;
    logic        in_transfer;
    tag_t        line_tag;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // request payload held until the response
    always_ff @(posedge clk) begin
        if (cpu_req_valid && cpu_req_ready) begin
            req_q <= cpu_req;
        end
    end

    assign tag   = req_q.addr[`DCACHE_ADDR_W-1 -: TAG_W];
    assign index = req_q.addr[BYTE_OFF_W+WORD_SEL_W +: INDEX_W];
    assign wstrb = req_q.wstrb;
    assign wdata = req_q.wdata;

    assign cpu_req_ready = (state == IDLE);
    assign beat_clear    = (state == IDLE); // counter starts from zero on every miss
    assign in_transfer   = (state == WRITEBACK) || (state == REFILL_REQ) || (state == REFILL_RESP);
    assign word_sel      = in_transfer ? beat : req_q.addr[BYTE_OFF_W +: WORD_SEL_W];
    assign data_way      = (state == LOOKUP) ? hit_way : victim_way;
    assign data_src_mem  = (state == REFILL_RESP);
    assign line_tag      = (state == WRITEBACK) ? victim_tag : tag;

    always_comb begin
        state_next     = state;
        cpu_resp_valid = 1'b0;
        mem_req_valid  = 1'b0;
        beat_advance   = 1'b0;
        data_we        = 1'b0;
        dirty_set      = 1'b0;
        lru_touch      = 1'b0;
        tag_install    = 1'b0;
        mem_req.write  = (state == WRITEBACK);
        mem_req.addr   = addr_t'({line_tag, index, beat, {BYTE_OFF_W{1'b0}}});
        mem_req.wdata  = '0; // line data is joined in at the top level
        case (state)
            IDLE: begin
                if (cpu_req_valid) state_next = LOOKUP;
            end
            LOOKUP: begin
                if (hit) begin
                    cpu_resp_valid = 1'b1;
                    lru_touch      = 1'b1;
                    data_we        = req_q.write; // byte merge of the store
                    dirty_set      = req_q.write;
                    state_next     = IDLE;
                end else begin
                    state_next = victim_dirty ? WRITEBACK : REFILL_REQ;
                end
            end
            WRITEBACK: begin
                mem_req_valid = 1'b1;
                if (mem_req_ready) begin
                    beat_advance = 1'b1;
                    if (last_beat) state_next = REFILL_REQ;
                end
            end
            REFILL_REQ: begin
                mem_req_valid = 1'b1;
                if (mem_req_ready) state_next = REFILL_RESP;
            end
            REFILL_RESP: begin
                if (mem_resp_valid) begin
                    data_we      = 1'b1;
                    beat_advance = 1'b1;
                    if (last_beat) begin
                        tag_install = 1'b1;
                        state_next  = REPLAY;
                    end else begin
                        state_next = REFILL_REQ; // next word only after this one
                    end
                end
            end
            REPLAY:  state_next = LOOKUP;
            default: state_next = IDLE;
        endcase
    end

endmodule

// ==== dcache/tag_store.sv ====
////////////////////
// tag, valid, dirty and lru state
// two-way hit check and victim choice per set
////////////////////
`timescale 1ns/1ps
`include "dcache_settings.svh"

module tag_store (
    input  logic               clk,
    input  logic               rst_n,
    input  dcache_pkg::index_t index,
    input  dcache_pkg::tag_t   tag,
    input  logic               tag_install,
    input  dcache_pkg::way_t   install_way,
    input  logic               lru_touch,
    input  logic               dirty_set,
    output logic               hit,
    output dcache_pkg::way_t   hit_way,
    output dcache_pkg::way_t   victim_way,
    output logic               victim_dirty,
    output dcache_pkg::tag_t   victim_tag
);
    import dcache_pkg::*;

    tag_t                    tags  [`DCACHE_WAYS][`DCACHE_SETS];
    logic [`DCACHE_SETS-1:0] valid [`DCACHE_WAYS];
    logic [`DCACHE_SETS-1:0] dirty [`DCACHE_WAYS];
    logic [`DCACHE_SETS-1:0] lru;  // way to evict next
    logic [`DCACHE_WAYS-1:0] way_hit;

    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            way_hit[w] = valid[w][index] && (tags[w][index] == tag);
        end
    end

    assign hit     = |way_hit;
    assign hit_way = way_t'(way_hit[1]);

    // an empty way wins over the lru way
    always_comb begin
        if (!valid[0][index]) begin
            victim_way = way_t'(0);
        end else if (!valid[1][index]) begin
            victim_way = way_t'(1);
        end else begin
            victim_way = way_t'(lru[index]);
        end
    end

    assign victim_dirty = valid[victim_way][index] && dirty[victim_way][index];
    assign victim_tag   = tags[victim_way][index];

    always_ff @(posedge clk) begin
        if (tag_install) tags[install_way][index] <= tag;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                valid[w] <= '0;
                dirty[w] <= '0;
            end
            lru <= '0;
        end else if (tag_install) begin
            valid[install_way][index] <= 1'b1;
            dirty[install_way][index] <= 1'b0;
            lru[index]                <= ~install_way; // filled way is now most recent
        end else begin
            if (lru_touch) lru[index] <= ~hit_way;
            if (dirty_set) dirty[hit_way][index] <= 1'b1;
        end
    end

endmodule

// ==== files.f ====
+incdir+common
common/dcache_pkg.sv
dcache/beat_counter.sv
dcache/tag_store.sv
dcache/data_store.sv
dcache/dcache_ctrl.sv
verilog/dcache_top.sv
tests/mem_model.sv
tests/tb_dcache.sv

// ==== tests/mem_model.sv ====
////////////////////
// behavioral word memory
// random ready stalls and read delays
////////////////////
`timescale 1ns/1ps

module mem_model (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_valid,
    input  dcache_pkg::mem_req_t req,
    output logic                 req_ready,
    output logic                 resp_valid,
    output dcache_pkg::word_t    rdata
);
    import dcache_pkg::*;

    word_t words [addr_t]; // only written words are kept

    function automatic word_t peek(addr_t a);
        if (words.exists(a)) return words[a];
        return ~a; // untouched words read as the inverted address
    endfunction

    initial begin
        mem_req_t beat_q;
        logic     accept, in_reset, rd_pending;
        addr_t    rd_addr;
        int       rd_wait;
        req_ready  = 1'b0;
        resp_valid = 1'b0;
        rdata      = '0;
        rd_pending = 1'b0;
        rd_addr    = '0;
        rd_wait    = 0;
        forever begin
            @(negedge clk); // request side is settled mid-cycle
            in_reset = !rst_n;
            accept   = rst_n && req_valid && req_ready;
            beat_q   = req;
            @(posedge clk);
            #1;
            resp_valid = 1'b0;
            if (in_reset) begin
                rd_pending = 1'b0;
            end else if (accept && beat_q.write) begin
                words[beat_q.addr] = beat_q.wdata;
            end else if (accept) begin
                rd_pending = 1'b1;
                rd_addr    = beat_q.addr;
                rd_wait    = $urandom_range(3, 0);
            end
            if (rd_pending && rd_wait == 0) begin
                resp_valid = 1'b1;
                rdata      = peek(rd_addr);
                rd_pending = 1'b0;
            end else if (rd_pending) begin
                rd_wait--;
            end
            req_ready = !in_reset && ($urandom_range(3, 0) != 0); // stall about one in four
        end
    end

endmodule

// ==== tests/tb_dcache.sv ====
////////////////////
// data cache testbench
// directed and random traffic against a shadow copy of memory
////////////////////
`timescale 1ns/1ps

module tb_dcache;
    import dcache_pkg::*;

    logic     clk = 1'b0;
    logic     rst_n, cpu_req_valid, cpu_req_ready, cpu_resp_valid;
    logic     mem_req_valid, mem_req_ready, mem_resp_valid;
    cpu_req_t cpu_req;
    mem_req_t mem_req;
    word_t    cpu_rdata, mem_rdata;

    word_t shadow [addr_t];    // words stored by the cpu so far
    string test_name = "reset";
    logic  exp_load = 1'b0;
    logic  expect_hit = 1'b0;
    logic  busy = 1'b0;        // between acceptance and response
    word_t exp_rdata = '0;

    always #2 clk = ~clk;

    dcache_top i_dut (
        .clk, .rst_n,
        .cpu_req_valid, .cpu_req, .cpu_req_ready, .cpu_resp_valid, .cpu_rdata,
        .mem_req_valid, .mem_req, .mem_req_ready, .mem_resp_valid, .mem_rdata
    );

    mem_model i_mem (
        .clk, .rst_n,
        .req_valid(mem_req_valid), .req(mem_req), .req_ready(mem_req_ready),
        .resp_valid(mem_resp_valid), .rdata(mem_rdata)
    );

    function automatic word_t shadow_word(addr_t a);
        if (shadow.exists(a)) return shadow[a];
        return ~a;
    endfunction

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    // all checks sample mid-cycle, where outputs are settled
    assert property (@(negedge clk) $rose(rst_n) |->
                     (cpu_req_ready && !cpu_resp_valid && !mem_req_valid))
        else fail_run("ports not idle after reset");
    assert property (@(negedge clk) disable iff (!rst_n)
                     (cpu_resp_valid && exp_load) |-> (cpu_rdata == exp_rdata))
        else fail_run($sformatf("error %s: expected %08h, actual %08h",
                                test_name, exp_rdata, cpu_rdata));
    assert property (@(negedge clk) disable iff (!rst_n)
                     (cpu_req_valid && cpu_req_ready && expect_hit) |=> cpu_resp_valid)
        else fail_run("hit response not one cycle after acceptance");
    assert property (@(negedge clk) disable iff (!rst_n) busy |-> !cpu_req_ready)
        else fail_run("cpu_req_ready high while a request is outstanding");
    assert property (@(negedge clk) disable iff (!rst_n) cpu_resp_valid |-> busy)
        else fail_run("response without an outstanding request");
    assert property (@(negedge clk) disable iff (!rst_n)
                     (mem_req_valid && !mem_req_ready) |=> (mem_req_valid && $stable(mem_req)))
        else fail_run("memory request changed while stalled");

    task automatic check_mem_word(addr_t a);
        word_t got;
        got = i_mem.peek(a);
        assert (got == shadow_word(a))
            else fail_run($sformatf("error %s: expected %08h, actual %08h",
                                    test_name, shadow_word(a), got));
    endtask

    task automatic access(input logic wr, input addr_t a, input word_t d, input strb_t s,
                          input logic hit_now);
        int    n;
        word_t merged;
        n = 0;
        while (!cpu_req_ready) begin
            @(posedge clk);
            #1;
            if (++n >= 200) fail_run("timeout waiting for cpu_req_ready");
        end
        exp_load      = !wr;
        exp_rdata     = shadow_word(a);
        expect_hit    = hit_now;
        cpu_req_valid = 1'b1;
        cpu_req       = '{write: wr, addr: a, wdata: d, wstrb: s};
        @(posedge clk);
        #1;
        cpu_req_valid = 1'b0;
        busy          = 1'b1;
        if (wr) begin
            merged = shadow_word(a);
            for (int b = 0; b < 4; b++) begin
                if (s[b]) merged[8*b +: 8] = d[8*b +: 8];
            end
            shadow[a] = merged;
        end
        n = 0;
        while (!cpu_resp_valid) begin
            @(posedge clk);
            #1;
            if (++n >= 200) fail_run("timeout waiting for cpu_resp_valid");
        end
        @(posedge clk); // response is checked mid-cycle
        #1;
        busy = 1'b0;
    endtask

    initial begin
        int    r;
        addr_t a;
        void'($urandom(78));
        rst_n         = 1'b0;
        cpu_req_valid = 1'b0;
        cpu_req       = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        test_name = "load_miss_hit";
        access(1'b0, 32'h0000_1040, '0, '0, 1'b0);
        access(1'b0, 32'h0000_1044, '0, '0, 1'b1);
        test_name = "partial_store";
        access(1'b1, 32'h0000_1048, 32'ha5a5_5a5a, 4'b0101, 1'b1);
        access(1'b0, 32'h0000_1048, '0, '0, 1'b1);
        test_name = "dirty_evict"; // three lines on set 8, two ways
        access(1'b1, 32'h0000_2080, 32'hdead_beef, 4'b1100, 1'b0);
        access(1'b0, 32'h0000_3080, '0, '0, 1'b0);
        access(1'b0, 32'h0000_4080, '0, '0, 1'b0);
        check_mem_word(32'h0000_2080);
        access(1'b0, 32'h0000_2080, '0, '0, 1'b0);
        test_name = "random_traffic";
        for (int i = 0; i < 300; i++) begin
            r = $urandom_range(47, 0);
            a = addr_t'(32'h0001_0000 + (r / 16) * 32'h100 + (r % 16) * 4); // sets 0 to 3
            access($urandom_range(1, 0) == 1, a, word_t'($urandom()),
                   strb_t'($urandom_range(15, 0)), 1'b0);
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== verilog/dcache_top.sv ====
////////////////////
// two-way write-back data cache
// cpu valid/ready port in front, word-wide memory port behind
////////////////////
`timescale 1ns/1ps

module dcache_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cpu_req_valid,
    input  dcache_pkg::cpu_req_t cpu_req,
    output logic                 cpu_req_ready,
    output logic                 cpu_resp_valid,
    output dcache_pkg::word_t    cpu_rdata,
    output logic                 mem_req_valid,
    output dcache_pkg::mem_req_t mem_req,
    input  logic                 mem_req_ready,
    input  logic                 mem_resp_valid,
    input  dcache_pkg::word_t    mem_rdata
);
    import dcache_pkg::*;

    mem_req_t  ctrl_mem_req;
    logic      hit, victim_dirty;
    way_t      hit_way, victim_way, data_way;
    tag_t      victim_tag, tag;
    word_sel_t beat, word_sel;
    logic      last_beat, beat_clear, beat_advance;
    index_t    index;
    strb_t     wstrb;
    word_t     wdata, rdata;
    logic      tag_install, lru_touch, dirty_set, data_we, data_src_mem;

    // write-back beats carry the victim word read from the array
    assign mem_req   = '{write: ctrl_mem_req.write, addr: ctrl_mem_req.addr, wdata: rdata};
    assign cpu_rdata = rdata;

    dcache_ctrl i_ctrl (
        .clk, .rst_n,
        .cpu_req_valid, .cpu_req, .cpu_req_ready, .cpu_resp_valid,
        .mem_req_valid, .mem_req(ctrl_mem_req), .mem_req_ready, .mem_resp_valid,
        .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
        .beat, .last_beat, .beat_clear, .beat_advance,
        .index, .tag, .word_sel, .wstrb, .wdata,
        .tag_install, .lru_touch, .dirty_set, .data_we, .data_way, .data_src_mem
    );

    beat_counter i_beat (
        .clk, .rst_n,
        .clear(beat_clear), .advance(beat_advance),
        .beat, .last_beat
    );

    tag_store i_tags (
        .clk, .rst_n,
        .index, .tag,
        .tag_install, .install_way(data_way), .lru_touch, .dirty_set,
        .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag
    );

    data_store i_data (
        .clk,
        .index, .word_sel, .way(data_way),
        .we(data_we), .wstrb, .wdata, .src_mem(data_src_mem), .mem_word(mem_rdata),
        .rdata
    );

endmodule
